/* Makefile */
TOP = control_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "Simulation ended without passing"; exit 1)

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* bench/control_unit_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit_properties (
    input logic                  clk,
    input logic                  reset,
    input cu_pkg::flags_t        flags,
    input cu_pkg::control_word_t control_word
);
    import cu_pkg::*;

    logic halt_seen;     // Set by a halt step, cleared by reset
    logic jump_checked;
    logic jump_true;

    // Check bits pass through to the execute half, so the test is visible here
    always_comb begin
        jump_checked = control_word.exec.check_zero | control_word.exec.check_not_zero
                     | control_word.exec.check_carry | control_word.exec.check_negative;
        jump_true = (control_word.exec.check_zero && flags.zero)
                  || (control_word.exec.check_not_zero && !flags.zero)
                  || (control_word.exec.check_carry && flags.carry)
                  || (control_word.exec.check_negative && flags.negative);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            halt_seen <= 1'b0;
        end else if (control_word.exec.halt) begin
            halt_seen <= 1'b1;
        end
    end

    // ======================================================================
    fetch_exec_exclusive: assert property (@(posedge clk) disable iff (reset)
        !((|control_word.fetch) && (|control_word.exec)))
        else $error("fetch and execute controls active in the same cycle");

    ir_load_advances_pc: assert property (@(posedge clk) disable iff (reset)
        control_word.fetch.load_ir |-> control_word.fetch.pc_enable)
        else $error("load_ir without pc_enable");

    failed_jump_keeps_pc: assert property (@(posedge clk) disable iff (reset)
        (jump_checked && !jump_true)
            |-> !(control_word.exec.load_pc_low_byte || control_word.exec.load_pc_high_byte))
        else $error("PC load in a cycle whose jump condition is false");

    halt_stays_quiet: assert property (@(posedge clk) disable iff (reset)
        halt_seen |-> (control_word == '0))
        else $error("control word active after a halt step");

endmodule

`default_nettype wire

/* bench/control_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit_tb;
    import cu_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;  // Several times the directed tests

    logic          clk;
    logic          reset;
    opcode_t       opcode;
    flags_t        flags;
    control_word_t control_word;

    integer        seed;
    int            cycle_count = 0;
    flags_t        exec_flags;       // Flags shown to the DUT while executing
    exec_ctrl_t    expected_steps[$];

    control_unit dut_i (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .flags        (flags),
        .control_word (control_word)
    );

    bind control_unit control_unit_properties props_i (
        .clk          (clk),
        .reset        (reset),
        .flags        (flags),
        .control_word (control_word)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d clock cycles", cycle_count);
            $display("TEST FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    // ======================================================================
    // Expected words, built from the instruction timing
    function automatic flags_t random_flags();
        logic [31:0] r;
        r = $random(seed);
        return flags_t'(r[2:0]);
    endfunction

    function automatic control_word_t fetch_word(fetch_ctrl_t f);
        control_word_t w;
        w = '0;
        w.fetch = f;
        return w;
    endfunction

    function automatic control_word_t exec_word(exec_ctrl_t e);
        control_word_t w;
        w = '0;
        w.exec = e;
        return w;
    endfunction

    function automatic exec_ctrl_t alu_setup_word(alu_op_t op, logic src1_b, logic src1_c,
                                                  logic src2_c, logic imm);
        exec_ctrl_t w;
        w = '0;
        w.alu_op         = op;
        w.alu_src1_b     = src1_b;
        w.alu_src1_c     = src1_c;
        w.alu_src2_c     = src2_c;
        w.oe_temp_1      = imm;  // Immediate operand from the first operand byte
        w.alu_src2_temp1 = imm;
        return w;
    endfunction

    function automatic exec_ctrl_t alu_result_word(logic to_a, logic to_b, logic to_c,
                                                   logic set_flags);
        exec_ctrl_t w;
        w = '0;
        w.oe_alu     = to_a | to_b | to_c;
        w.load_a     = to_a;
        w.load_b     = to_b;
        w.load_c     = to_c;
        w.load_flags = set_flags;
        w.last_step  = 1'b1;
        return w;
    endfunction

    function automatic exec_ctrl_t jump_low_word(logic cz, logic cnz, logic cn, logic taken);
        exec_ctrl_t w;
        w = '0;
        w.oe_temp_1        = 1'b1;
        w.load_pc_low_byte = taken;
        w.check_zero       = cz;
        w.check_not_zero   = cnz;
        w.check_negative   = cn;
        return w;
    endfunction

    function automatic exec_ctrl_t jump_high_word();
        exec_ctrl_t w;
        w = '0;
        w.oe_temp_2         = 1'b1;
        w.load_pc_high_byte = 1'b1;
        w.last_step         = 1'b1;
        return w;
    endfunction

    // ======================================================================
    // Drive and check helpers, each called at the drive point of a cycle
    task automatic check(input bit ok, input string what);
        assert (ok) else begin
            $display("CHECK FAILED at %0t ns: %s", $time, what);
            $display("TEST FAIL");
            $fatal(1, "stopping at first failed check");
        end
    endtask

    task automatic expect_word(input control_word_t expected, input string what);
        #4;  // Middle of the cycle
        check(control_word === expected,
              $sformatf("%s: got %h, expected %h", what, control_word, expected));
        @(posedge clk);
        #1;
    endtask

    task automatic expect_idle(input int cycles, input string what);
        for (int i = 0; i < cycles; i++) begin
            flags = random_flags();
            expect_word('0, what);
        end
    endtask

    task automatic apply_reset();
        fetch_ctrl_t f;
        reset = 1'b1;
        opcode = NOP;
        flags = random_flags();
        @(posedge clk);
        #1;
        repeat (9) expect_word('0, "during reset");
        reset = 1'b0;
        expect_word('0, "idle cycle after reset");
        f = '0;
        f.load_origin = 1'b1;
        expect_word(fetch_word(f), "origin load");
    endtask

    task automatic fetch_instruction(input opcode_t op, input int nbytes);
        fetch_ctrl_t f;
        for (int i = 0; i < nbytes; i++) begin
            flags = random_flags();
            f = '0;
            f.load_mar_pc = 1'b1;
            expect_word(fetch_word(f), "latch address");
            f = '0;
            f.oe_ram = 1'b1;
            expect_word(fetch_word(f), "read byte");
            f.pc_enable   = 1'b1;
            f.load_ir     = (i == 0);
            f.load_temp_1 = (i == 1);
            f.load_temp_2 = (i == 2);
            expect_word(fetch_word(f), $sformatf("latch byte %0d", i));
            if (i == 0) begin
                opcode = op;  // Instruction register follows load_ir
            end
            expect_word('0, "check cycle");
        end
    endtask

    task automatic run_instruction(input opcode_t op, input int nbytes, input string name);
        fetch_instruction(op, nbytes);
        foreach (expected_steps[i]) begin
            flags = exec_flags;
            expect_word(exec_word(expected_steps[i]), $sformatf("%s step %0d", name, i));
        end
        expected_steps.delete();
    endtask

    task automatic run_alu(input opcode_t op, input int nbytes, input exec_ctrl_t setup,
                           input exec_ctrl_t result, input string name);
        exec_flags = random_flags();
        expected_steps.push_back(setup);
        expected_steps.push_back(result);
        run_instruction(op, nbytes, name);
    endtask

    task automatic run_jump(input opcode_t op, input logic cz, input logic cnz,
                            input logic cn, input logic taken, input string name);
        expected_steps.push_back(jump_low_word(cz, cnz, cn, taken));
        if (taken) begin
            expected_steps.push_back(jump_high_word());
        end
        run_instruction(op, 3, name);
    endtask

    task automatic push_address_steps();
        exec_ctrl_t w;
        w = '0;
        w.oe_temp_1 = 1'b1;
        expected_steps.push_back(w);
        w.load_mar_addr_low = 1'b1;
        expected_steps.push_back(w);
        w = '0;
        w.oe_temp_2 = 1'b1;
        expected_steps.push_back(w);
        w.load_mar_addr_high = 1'b1;
        expected_steps.push_back(w);
    endtask

    // ======================================================================
    // Directed tests
    task automatic test_reset_init();
        exec_ctrl_t w;
        apply_reset();
        w = '0;
        w.last_step = 1'b1;
        exec_flags = random_flags();
        expected_steps.push_back(w);
        run_instruction(NOP, 1, "NOP after reset");
    endtask

    task automatic test_fetch_lengths();
        exec_ctrl_t w;
        w = '0;
        w.last_step = 1'b1;
        exec_flags = random_flags();
        expected_steps.push_back(w);
        run_instruction(NOP, 1, "NOP");
        w.oe_temp_1    = 1'b1;
        w.load_a       = 1'b1;
        w.load_flags   = 1'b1;
        w.load_sets_zn = 1'b1;
        expected_steps.push_back(w);
        run_instruction(LDI_A, 2, "LDI_A");
        exec_flags = random_flags();
        run_jump(JMP, 1'b0, 1'b0, 1'b0, 1'b1, "JMP");
    endtask

    task automatic test_alu_moves();
        exec_ctrl_t w;
        run_alu(ADD_C, 1, alu_setup_word(ALU_ADD, 0, 0, 1, 0), alu_result_word(1, 0, 0, 1),
                "ADD_C");
        run_alu(SBC_B, 1, alu_setup_word(ALU_SBC, 0, 0, 0, 0), alu_result_word(1, 0, 0, 1),
                "SBC_B");
        run_alu(ANI, 2, alu_setup_word(ALU_AND, 0, 0, 0, 1), alu_result_word(1, 0, 0, 1),
                "ANI");
        run_alu(CMP_B, 1, alu_setup_word(ALU_SUB, 0, 0, 0, 0), alu_result_word(0, 0, 0, 1),
                "CMP_B");
        run_alu(RAR, 1, alu_setup_word(ALU_ROR, 0, 0, 0, 0), alu_result_word(1, 0, 0, 0),
                "RAR");
        run_alu(INR_C, 1, alu_setup_word(ALU_INR, 0, 1, 0, 0), alu_result_word(0, 0, 1, 1),
                "INR_C");
        w = '0;
        w.oe_b      = 1'b1;
        w.load_c    = 1'b1;
        w.last_step = 1'b1;
        expected_steps.push_back(w);
        run_instruction(MOV_BC, 1, "MOV_BC");
    endtask

    task automatic test_jumps();
        flags_t f;
        f = random_flags();
        f.zero = 1'b1;
        exec_flags = f;
        run_jump(JZ, 1'b1, 1'b0, 1'b0, 1'b1, "JZ taken");
        run_jump(JNZ, 1'b0, 1'b1, 1'b0, 1'b0, "JNZ not taken");
        f.zero = 1'b0;
        exec_flags = f;
        run_jump(JZ, 1'b1, 1'b0, 1'b0, 1'b0, "JZ not taken");
        run_jump(JNZ, 1'b0, 1'b1, 1'b0, 1'b1, "JNZ taken");
        f.negative = 1'b1;
        exec_flags = f;
        run_jump(JN, 1'b0, 1'b0, 1'b1, 1'b1, "JN taken");
        f.negative = 1'b0;
        exec_flags = f;
        run_jump(JN, 1'b0, 1'b0, 1'b1, 1'b0, "JN not taken");
        repeat (2) begin
            exec_flags = random_flags();
            run_jump(JMP, 1'b0, 1'b0, 1'b0, 1'b1, "JMP any flags");
        end
    endtask

    task automatic test_memory();
        exec_ctrl_t w;
        exec_flags = random_flags();
        push_address_steps();
        w = '0;
        w.oe_ram = 1'b1;
        expected_steps.push_back(w);
        w.load_a       = 1'b1;
        w.load_flags   = 1'b1;
        w.load_sets_zn = 1'b1;
        w.last_step    = 1'b1;
        expected_steps.push_back(w);
        run_instruction(LDA, 3, "LDA");
        push_address_steps();
        w = '0;
        w.oe_a = 1'b1;
        expected_steps.push_back(w);
        w.load_ram  = 1'b1;
        w.last_step = 1'b1;
        expected_steps.push_back(w);
        run_instruction(STA, 3, "STA");
        w = '0;
        w.oe_temp_1    = 1'b1;
        w.load_c       = 1'b1;
        w.load_flags   = 1'b1;
        w.load_sets_zn = 1'b1;
        w.last_step    = 1'b1;
        expected_steps.push_back(w);
        run_instruction(LDI_C, 2, "LDI_C");
    endtask

    task automatic test_halt();
        exec_ctrl_t w;
        w = '0;
        w.halt = 1'b1;
        exec_flags = random_flags();
        expected_steps.push_back(w);
        run_instruction(HLT, 1, "HLT");
        expect_idle(20, "halted after HLT");
        test_reset_init();  // Restart after halt
        expected_steps.push_back(w);
        run_instruction(opcode_t'(8'hff), 1, "unused opcode");
        expect_idle(20, "halted after unused opcode");
        test_reset_init();
    endtask

    // ======================================================================
    initial begin
        fetch_ctrl_t next_fetch;
        seed       = 32'hc1ce3e09;
        reset      = 1'b1;
        opcode     = NOP;
        flags      = '0;
        exec_flags = '0;
        test_reset_init();
        test_fetch_lengths();
        test_alu_moves();
        test_jumps();
        test_memory();
        test_halt();
        next_fetch = '0;
        next_fetch.load_mar_pc = 1'b1;
        expect_word(fetch_word(next_fetch), "fetch after final NOP");
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/cu_pkg.sv
verilog/fetch_sequencer.sv
verilog/microstep_sequencer.sv
verilog/microcode_rom.sv
verilog/control_unit.sv
bench/control_unit_properties.sv
bench/control_unit_tb.sv

/* verilog/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  cu_pkg::opcode_t       opcode,
    input  cu_pkg::flags_t        flags,
    output cu_pkg::control_word_t control_word
);
    import cu_pkg::*;

    fetch_ctrl_t  fetch_ctrl;
    exec_ctrl_t   exec_ctrl;
    exec_ctrl_t   rom_word;
    exec_status_t exec_status;
    microstep_t   microstep;
    logic         exec_active;

    fetch_sequencer fetch_i (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .exec_status (exec_status),
        .fetch_ctrl  (fetch_ctrl),
        .exec_active (exec_active)
    );

    microstep_sequencer step_i (
        .clk         (clk),
        .reset       (reset),
        .exec_active (exec_active),
        .flags       (flags),
        .rom_word    (rom_word),
        .microstep   (microstep),
        .exec_ctrl   (exec_ctrl),
        .exec_status (exec_status)
    );

    microcode_rom rom_i (
        .opcode    (opcode),
        .microstep (microstep),
        .rom_word  (rom_word)
    );

    assign control_word = '{fetch: fetch_ctrl, exec: exec_ctrl};

endmodule

`default_nettype wire

/* verilog/cu_pkg.sv */
`default_nettype none

`include "cu_settings.svh"

package cu_pkg;

    // ==================================================================
    // Instruction set, grouped by operand count in the high nibble
    typedef enum logic [`CU_OPCODE_WIDTH-1:0] {
        NOP    = 8'h00,
        HLT    = 8'h01,
        JMP    = 8'h10,  // Two operand bytes from here
        JZ     = 8'h11,
        JNZ    = 8'h12,
        JN     = 8'h13,
        LDA    = 8'h14,
        STA    = 8'h15,
        LDI_A  = 8'h20,  // One operand byte
        LDI_B  = 8'h21,
        LDI_C  = 8'h22,
        ANI    = 8'h23,
        ORI    = 8'h24,
        XRI    = 8'h25,
        ADD_B  = 8'h30,  // Register arithmetic
        ADD_C  = 8'h31,
        SUB_B  = 8'h32,
        SUB_C  = 8'h33,
        ADC_B  = 8'h34,
        ADC_C  = 8'h35,
        SBC_B  = 8'h36,
        SBC_C  = 8'h37,
        INR_A  = 8'h38,
        DCR_A  = 8'h39,
        ANA_B  = 8'h40,  // Logic, compare, rotate
        ANA_C  = 8'h41,
        ORA_B  = 8'h42,
        ORA_C  = 8'h43,
        XRA_B  = 8'h44,
        XRA_C  = 8'h45,
        CMP_B  = 8'h46,
        CMP_C  = 8'h47,
        RAR    = 8'h48,
        RAL    = 8'h49,
        CMA    = 8'h4a,
        INR_B  = 8'h50,
        DCR_B  = 8'h51,
        INR_C  = 8'h52,
        DCR_C  = 8'h53,
        MOV_AB = 8'h60,  // Register moves
        MOV_AC = 8'h61,
        MOV_BA = 8'h62,
        MOV_BC = 8'h63,
        MOV_CA = 8'h64,
        MOV_CB = 8'h65
    } opcode_t;

    typedef enum logic [`CU_ALU_OP_WIDTH-1:0] {
        ALU_UNDEFINED = 4'd0,
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_INR, ALU_DCR,
        ALU_AND, ALU_OR, ALU_XOR,
        ALU_ROR, ALU_ROL, ALU_INV
    } alu_op_t;

    typedef enum logic [$clog2(`CU_MICROSTEPS)-1:0] {
        MS0, MS1, MS2, MS3, MS4, MS5, MS6, MS7
    } microstep_t;

    typedef struct packed {
        logic negative;
        logic carry;
        logic zero;
    } flags_t;

    // ==================================================================
    // Control words
    typedef struct packed {
        logic load_origin;
        logic load_mar_pc;
        logic oe_ram;
        logic pc_enable;
        logic load_ir;
        logic load_temp_1;
        logic load_temp_2;
    } fetch_ctrl_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src1_b;
        logic    alu_src1_c;
        logic    alu_src2_c;
        logic    alu_src2_temp1;
        logic    oe_a;
        logic    oe_b;
        logic    oe_c;
        logic    oe_alu;
        logic    oe_temp_1;
        logic    oe_temp_2;
        logic    oe_ram;  // ORed with the fetch copy in the datapath
        logic    load_a;
        logic    load_b;
        logic    load_c;
        logic    load_flags;
        logic    load_sets_zn;  // Flags taken from the bus value
        logic    load_ram;
        logic    load_pc_low_byte;
        logic    load_pc_high_byte;
        logic    load_mar_addr_low;
        logic    load_mar_addr_high;
        logic    check_zero;
        logic    check_not_zero;
        logic    check_carry;
        logic    check_negative;
        logic    last_step;
        logic    halt;
    } exec_ctrl_t;

    typedef struct packed {
        fetch_ctrl_t fetch;
        exec_ctrl_t  exec;
    } control_word_t;

    typedef struct packed {
        logic done;
        logic halted;
    } exec_status_t;

endpackage

`default_nettype wire

/* verilog/cu_settings.svh */
`ifndef CU_SETTINGS_SVH
`define CU_SETTINGS_SVH

// ======================================================================
// Control unit sizing

// Instruction register width
`define CU_OPCODE_WIDTH 8

// Microsteps available to one opcode
`define CU_MICROSTEPS 8

// Largest operand byte count after the opcode byte
`define CU_MAX_OPERANDS 2

// ALU operation select width
`define CU_ALU_OP_WIDTH 4

`endif

/* verilog/fetch_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cu_settings.svh"

module fetch_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  cu_pkg::opcode_t      opcode,
    input  cu_pkg::exec_status_t exec_status,
    output cu_pkg::fetch_ctrl_t  fetch_ctrl,
    output logic                 exec_active
);
    import cu_pkg::*;

    localparam int COUNT_WIDTH = $clog2(`CU_MAX_OPERANDS + 2);

    typedef enum logic [2:0] {
        S_RESET,
        S_INIT,
        S_LATCH_ADDR,
        S_READ_BYTE,
        S_LATCH_BYTE,
        S_CHECK,
        S_EXECUTE,
        S_HALT
    } state_t;

    state_t                 state;
    state_t                 next_state;
    logic [COUNT_WIDTH-1:0] byte_count;      // Bytes fetched so far
    logic [COUNT_WIDTH-1:0] next_byte_count;
    logic [COUNT_WIDTH-1:0] operand_count;

    // ======================================================================
    // Operand bytes following each opcode
    always_comb begin
        case (opcode)
            LDI_A, LDI_B, LDI_C, ANI, ORI, XRI:
                operand_count = COUNT_WIDTH'(1);
            JMP, JZ, JNZ, JN, LDA, STA:
                operand_count = COUNT_WIDTH'(`CU_MAX_OPERANDS);
            default:
                operand_count = '0;  // Register, ALU, control and unknown
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_RESET;
            byte_count <= '0;
        end else begin
            state      <= next_state;
            byte_count <= next_byte_count;
        end
    end

    // ======================================================================
    // Next state and fetch controls
    always_comb begin
        next_state      = state;
        next_byte_count = byte_count;
        fetch_ctrl      = '0;
        case (state)
            S_RESET: next_state = S_INIT;
            S_INIT: begin
                fetch_ctrl.load_origin = 1'b1;
                next_state             = S_LATCH_ADDR;
            end
            S_LATCH_ADDR: begin
                fetch_ctrl.load_mar_pc = 1'b1;
                next_state             = S_READ_BYTE;
            end
            S_READ_BYTE: begin
                fetch_ctrl.oe_ram = 1'b1;  // Give the RAM a cycle to drive
                next_state        = S_LATCH_BYTE;
            end
            S_LATCH_BYTE: begin
                fetch_ctrl.oe_ram    = 1'b1;
                fetch_ctrl.pc_enable = 1'b1;
                fetch_ctrl.load_ir     = (byte_count == COUNT_WIDTH'(0));
                fetch_ctrl.load_temp_1 = (byte_count == COUNT_WIDTH'(1));
                fetch_ctrl.load_temp_2 = (byte_count == COUNT_WIDTH'(2));
                next_byte_count = byte_count + 1'b1;
                next_state      = S_CHECK;
            end
            S_CHECK: begin
                // Opcode plus all operands in hand
                if (byte_count > operand_count) begin
                    next_state      = S_EXECUTE;
                    next_byte_count = '0;
                end else begin
                    next_state = S_LATCH_ADDR;
                end
            end
            S_EXECUTE: begin
                if (exec_status.done) begin
                    next_state = exec_status.halted ? S_HALT : S_LATCH_ADDR;
                end
            end
            S_HALT: next_state = S_HALT;  // Held until reset
            default: next_state = S_HALT;
        endcase
    end

    assign exec_active = (state == S_EXECUTE);

endmodule

`default_nettype wire

/* verilog/microcode_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module microcode_rom (
    input  cu_pkg::opcode_t    opcode,
    input  cu_pkg::microstep_t microstep,
    output cu_pkg::exec_ctrl_t rom_word
);
    import cu_pkg::*;

    exec_ctrl_t alu_setup;   // MS0 word of a two-step ALU instruction
    exec_ctrl_t alu_result;  // MS1 word, writes the result back
    logic       is_alu;

    // ======================================================================
    // ALU instruction words
    always_comb begin
        alu_setup             = '0;
        alu_result            = '0;
        alu_result.oe_alu     = 1'b1;
        alu_result.load_a     = 1'b1;
        alu_result.load_flags = 1'b1;
        alu_result.last_step  = 1'b1;
        is_alu                = 1'b1;
        case (opcode)
            ADD_B, ADD_C: alu_setup.alu_op = ALU_ADD;
            SUB_B, SUB_C: alu_setup.alu_op = ALU_SUB;
            ADC_B, ADC_C: alu_setup.alu_op = ALU_ADC;
            SBC_B, SBC_C: alu_setup.alu_op = ALU_SBC;
            ANA_B, ANA_C, ANI: alu_setup.alu_op = ALU_AND;
            ORA_B, ORA_C, ORI: alu_setup.alu_op = ALU_OR;
            XRA_B, XRA_C, XRI: alu_setup.alu_op = ALU_XOR;
            INR_A, INR_B, INR_C: alu_setup.alu_op = ALU_INR;
            DCR_A, DCR_B, DCR_C: alu_setup.alu_op = ALU_DCR;
            RAR: alu_setup.alu_op = ALU_ROR;
            RAL: alu_setup.alu_op = ALU_ROL;
            CMA: alu_setup.alu_op = ALU_INV;
            CMP_B, CMP_C: begin
                alu_setup.alu_op  = ALU_SUB;
                alu_result.oe_alu = 1'b0;  // Flags only
                alu_result.load_a = 1'b0;
            end
            default: is_alu = 1'b0;
        endcase

        // Second operand and destination variants
        case (opcode)
            ADD_C, SUB_C, ADC_C, SBC_C, ANA_C, ORA_C, XRA_C, CMP_C:
                alu_setup.alu_src2_c = 1'b1;
            ANI, ORI, XRI: begin
                alu_setup.oe_temp_1      = 1'b1;
                alu_setup.alu_src2_temp1 = 1'b1;
            end
            RAR, RAL, CMA: alu_result.load_flags = 1'b0;
            INR_B, DCR_B: begin
                alu_setup.alu_src1_b = 1'b1;
                alu_result.load_a    = 1'b0;
                alu_result.load_b    = 1'b1;
            end
            INR_C, DCR_C: begin
                alu_setup.alu_src1_c = 1'b1;
                alu_result.load_a    = 1'b0;
                alu_result.load_c    = 1'b1;
            end
            default: ;
        endcase
    end

    // ======================================================================
    // Table lookup by opcode and microstep
    always_comb begin
        rom_word = '0;
        if (is_alu) begin
            if (microstep == MS0) rom_word = alu_setup;
            else if (microstep == MS1) rom_word = alu_result;
        end else begin
            case (opcode)
                NOP: rom_word.last_step = (microstep == MS0);
                JMP, JZ, JNZ, JN: begin
                    if (microstep == MS0) begin
                        rom_word.oe_temp_1        = 1'b1;
                        rom_word.load_pc_low_byte = 1'b1;
                        rom_word.check_zero       = (opcode == JZ);
                        rom_word.check_not_zero   = (opcode == JNZ);
                        rom_word.check_negative   = (opcode == JN);
                    end else if (microstep == MS1) begin
                        rom_word.oe_temp_2         = 1'b1;
                        rom_word.load_pc_high_byte = 1'b1;
                        rom_word.last_step         = 1'b1;
                    end
                end
                LDA, STA: begin
                    case (microstep)
                        MS0: rom_word.oe_temp_1 = 1'b1;
                        MS1: begin
                            rom_word.oe_temp_1         = 1'b1;
                            rom_word.load_mar_addr_low = 1'b1;
                        end
                        MS2: rom_word.oe_temp_2 = 1'b1;
                        MS3: begin
                            rom_word.oe_temp_2          = 1'b1;
                            rom_word.load_mar_addr_high = 1'b1;
                        end
                        MS4, MS5: begin
                            rom_word.oe_ram    = (opcode == LDA);  // Read path
                            rom_word.oe_a      = (opcode == STA);  // Write path
                            rom_word.last_step = (microstep == MS5);
                            if (microstep == MS5) begin
                                rom_word.load_a       = (opcode == LDA);
                                rom_word.load_flags   = (opcode == LDA);
                                rom_word.load_sets_zn = (opcode == LDA);
                                rom_word.load_ram     = (opcode == STA);
                            end
                        end
                        default: ;
                    endcase
                end
                LDI_A, LDI_B, LDI_C: begin
                    if (microstep == MS0) begin
                        rom_word.oe_temp_1    = 1'b1;
                        rom_word.load_a       = (opcode == LDI_A);
                        rom_word.load_b       = (opcode == LDI_B);
                        rom_word.load_c       = (opcode == LDI_C);
                        rom_word.load_flags   = 1'b1;
                        rom_word.load_sets_zn = 1'b1;
                        rom_word.last_step    = 1'b1;
                    end
                end
                MOV_AB, MOV_AC, MOV_BA, MOV_BC, MOV_CA, MOV_CB: begin
                    if (microstep == MS0) begin
                        rom_word.oe_a      = (opcode == MOV_AB) || (opcode == MOV_AC);
                        rom_word.oe_b      = (opcode == MOV_BA) || (opcode == MOV_BC);
                        rom_word.oe_c      = (opcode == MOV_CA) || (opcode == MOV_CB);
                        rom_word.load_a    = (opcode == MOV_BA) || (opcode == MOV_CA);
                        rom_word.load_b    = (opcode == MOV_AB) || (opcode == MOV_CB);
                        rom_word.load_c    = (opcode == MOV_AC) || (opcode == MOV_BC);
                        rom_word.last_step = 1'b1;
                    end
                end
                default: rom_word.halt = (microstep == MS0);  // HLT and unknown opcodes
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/microstep_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module microstep_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 exec_active,
    input  cu_pkg::flags_t       flags,
    input  cu_pkg::exec_ctrl_t   rom_word,
    output cu_pkg::microstep_t   microstep,
    output cu_pkg::exec_ctrl_t   exec_ctrl,
    output cu_pkg::exec_status_t exec_status
);
    import cu_pkg::*;

    logic check_jump;   // Step carries a jump condition
    logic jump_taken;
    logic jump_failed;

    // ======================================================================
    // Jump condition test
    always_comb begin
        check_jump = rom_word.check_zero | rom_word.check_not_zero
                   | rom_word.check_carry | rom_word.check_negative;
        jump_taken = (rom_word.check_zero && flags.zero)
                   || (rom_word.check_not_zero && !flags.zero)
                   || (rom_word.check_carry && flags.carry)
                   || (rom_word.check_negative && flags.negative);
        jump_failed = exec_active && check_jump && !jump_taken;
    end

    // ======================================================================
    // Execute half of the control word
    always_comb begin
        exec_ctrl = exec_active ? rom_word : '0;
        if (jump_failed) begin
            // Condition false so the PC keeps pointing past the operands
            exec_ctrl.load_pc_low_byte  = 1'b0;
            exec_ctrl.load_pc_high_byte = 1'b0;
        end
        exec_status.halted = exec_active && rom_word.halt;
        exec_status.done   = exec_active
                           && (rom_word.last_step || rom_word.halt || jump_failed);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            microstep <= MS0;
        end else if (exec_status.done) begin
            microstep <= MS0;  // Next instruction starts at the top
        end else if (exec_active) begin
            microstep <= microstep_t'(microstep + 1'b1);
        end
    end

endmodule

`default_nettype wire
